//--- build.f
+incdir+logic
logic/octree_store_pkg.sv
logic/op_decoder.sv
logic/feature_sequencer.sv
logic/feature_writeback.sv
logic/sram_bank.sv
logic/octree_store_top.sv
sim/tb_clock_gen.sv
sim/octree_store_sva.sv
sim/octree_store_tb.sv

//--- logic/feature_sequencer.sv
module feature_sequencer
  import octree_store_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start_i,
  input  op_code_t   op_i,
  input  slot_t      slot_i,
  output logic       rd_io_o,
  output logic       rd_loc_o,
  output sram_addr_t rd_addr_o,
  output logic       item_valid_o,
  output sram_addr_t item_addr_o,
  output logic       item_to_loc_o,
  output logic       item_zero_o,
  output logic       item_last_o
);

  `include "octree_store_config.svh"

  localparam sram_addr_t FEATURE_BASE = sram_addr_t'(`OS_FEATURE_BASE);
  localparam sram_addr_t INPUT_BASE   = sram_addr_t'(`OS_INPUT_BASE);
  localparam sram_addr_t OUTPUT_BASE  = sram_addr_t'(`OS_OUTPUT_BASE);
  localparam sram_addr_t FEAT_LEN     = sram_addr_t'(`OS_FEATURE_LENGTH);
  localparam item_cnt_t  LAST_ITEM    = item_cnt_t'(`OS_FEATURE_LENGTH - 1);

  logic       active;
  item_cnt_t  cnt;
  logic       is_add;
  logic       is_search;
  logic       is_del;
  sram_addr_t slot_addr;
  sram_addr_t io_addr;

  ////////////////////
  // Item counter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active <= 1'b0;
      cnt    <= '0;
    end else if (start_i) begin
      active <= 1'b1;
      cnt    <= '0;
    end else if (active) begin
      if (cnt == LAST_ITEM) begin
        active <= 1'b0;
        cnt    <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  assign is_add    = (op_i == OP_ADD);
  assign is_search = (op_i == OP_SEARCH);
  assign is_del    = (op_i == OP_DEL);

  ////////////////////
  // Address forming
  assign slot_addr = FEATURE_BASE + sram_addr_t'(slot_i) * FEAT_LEN + sram_addr_t'(cnt);

  // Input region for add, output region for search
  assign io_addr = (is_search ? OUTPUT_BASE : INPUT_BASE) + sram_addr_t'(cnt);

  // Source read, none for delete
  assign rd_io_o   = active && is_add;
  assign rd_loc_o  = active && is_search;
  assign rd_addr_o = is_add ? io_addr : slot_addr;

  // Tag for the write-back stage
  assign item_valid_o  = active;
  assign item_addr_o   = is_search ? io_addr : slot_addr;
  assign item_to_loc_o = !is_search;
  assign item_zero_o   = is_del;
  assign item_last_o   = active && (cnt == LAST_ITEM);

endmodule

//--- logic/feature_writeback.sv
module feature_writeback
  import octree_store_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       item_valid_i,
  input  sram_addr_t item_addr_i,
  input  logic       item_to_loc_i,
  input  logic       item_zero_i,
  input  logic       item_last_i,
  input  word_t      io_rdata_i,
  input  word_t      loc_rdata_i,
  output logic       wr_io_o,
  output logic       wr_loc_o,
  output sram_addr_t wr_addr_o,
  output word_t      wr_data_o,
  output logic       last_write_o
);

  logic       valid_q;
  logic       last_q;
  sram_addr_t addr_q;
  logic       to_loc_q;
  logic       zero_q;

  ////////////////////
  // Tag delay, matches the read latency
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      valid_q <= item_valid_i;
      last_q  <= item_valid_i && item_last_i;
    end
  end

  always_ff @(posedge clk) begin
    addr_q   <= item_addr_i;
    to_loc_q <= item_to_loc_i;
    zero_q   <= item_zero_i;
  end

  // Data comes from the bank opposite the destination
  always_comb begin
    if (zero_q) begin
      wr_data_o = '0;
    end else if (to_loc_q) begin
      wr_data_o = io_rdata_i;
    end else begin
      wr_data_o = loc_rdata_i;
    end
  end

  assign wr_io_o      = valid_q && !to_loc_q;
  assign wr_loc_o     = valid_q && to_loc_q;
  assign wr_addr_o    = addr_q;
  assign last_write_o = valid_q && last_q;

endmodule

//--- logic/octree_store_config.svh
`ifndef OCTREE_STORE_CONFIG_SVH
`define OCTREE_STORE_CONFIG_SVH

// Words per anchor feature
`define OS_FEATURE_LENGTH 10
`define OS_TREE_LEVEL     4

// Level field plus one octant offset per tree level
`define OS_ENCODE_W       (2 + 3 * `OS_TREE_LEVEL)

`define OS_ADDR_W         10
`define OS_DATA_W         64

////////////////////
// Region bases
`define OS_FEATURE_BASE   400  // Slot area, local bank
`define OS_INPUT_BASE     0    // In/out bank
`define OS_OUTPUT_BASE    10   // In/out bank

`endif

//--- logic/octree_store_pkg.sv
package octree_store_pkg;

  `include "octree_store_config.svh"

  typedef logic [`OS_DATA_W-1:0]   word_t;
  typedef logic [`OS_ADDR_W-1:0]   sram_addr_t;
  typedef logic [`OS_ENCODE_W-1:0] pos_encode_t;

  // Last-level octant offset
  typedef logic [2:0] slot_t;

  typedef logic [$clog2(`OS_FEATURE_LENGTH)-1:0] item_cnt_t;

  ////////////////////
  // Command and status codes
  typedef enum logic [1:0] {
    OP_IDLE   = 2'd0,
    OP_SEARCH = 2'd1,
    OP_ADD    = 2'd2,
    OP_DEL    = 2'd3
  } op_code_t;

  typedef enum logic [1:0] {
    DONE_NONE   = 2'd0,
    DONE_SEARCH = 2'd1,
    DONE_ADD    = 2'd2,
    DONE_DEL    = 2'd3
  } done_code_t;

endpackage

//--- logic/octree_store_top.sv
module octree_store_top
  import octree_store_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  op_code_t    op_i,
  input  pos_encode_t pos_encode_i,
  output done_code_t  done_o,
  input  logic        host_en_i,
  // In/out bank host port
  input  logic        io_req_i,
  input  logic        io_we_i,
  input  sram_addr_t  io_addr_i,
  input  word_t       io_wdata_i,
  output word_t       io_rdata_o,
  // Local bank host port
  input  logic        loc_req_i,
  input  logic        loc_we_i,
  input  sram_addr_t  loc_addr_i,
  input  word_t       loc_wdata_i,
  output word_t       loc_rdata_o
);

  logic       start;
  op_code_t   op;
  slot_t      slot;
  logic       last_write;

  logic       rd_io;
  logic       rd_loc;
  sram_addr_t rd_addr;
  logic       item_valid;
  sram_addr_t item_addr;
  logic       item_to_loc;
  logic       item_zero;
  logic       item_last;

  logic       wr_io;
  logic       wr_loc;
  sram_addr_t wr_addr;
  word_t      wr_data;
  word_t      io_eng_rdata;
  word_t      loc_eng_rdata;

  ////////////////////
  // Command pipeline
  op_decoder u_op_decoder (
    .clk          (clk),
    .rst_n        (rst_n),
    .op_i         (op_i),
    .pos_encode_i (pos_encode_i),
    .host_en_i    (host_en_i),
    .last_write_i (last_write),
    .start_o      (start),
    .op_o         (op),
    .slot_o       (slot),
    .done_o       (done_o)
  );

  feature_sequencer u_feature_sequencer (
    .clk           (clk),
    .rst_n         (rst_n),
    .start_i       (start),
    .op_i          (op),
    .slot_i        (slot),
    .rd_io_o       (rd_io),
    .rd_loc_o      (rd_loc),
    .rd_addr_o     (rd_addr),
    .item_valid_o  (item_valid),
    .item_addr_o   (item_addr),
    .item_to_loc_o (item_to_loc),
    .item_zero_o   (item_zero),
    .item_last_o   (item_last)
  );

  feature_writeback u_feature_writeback (
    .clk           (clk),
    .rst_n         (rst_n),
    .item_valid_i  (item_valid),
    .item_addr_i   (item_addr),
    .item_to_loc_i (item_to_loc),
    .item_zero_i   (item_zero),
    .item_last_i   (item_last),
    .io_rdata_i    (io_eng_rdata),
    .loc_rdata_i   (loc_eng_rdata),
    .wr_io_o       (wr_io),
    .wr_loc_o      (wr_loc),
    .wr_addr_o     (wr_addr),
    .wr_data_o     (wr_data),
    .last_write_o  (last_write)
  );

  ////////////////////
  // Banks
  sram_bank u_io_bank (
    .clk (clk), .rst_n (rst_n), .host_en_i (host_en_i),
    .host_req_i    (io_req_i),
    .host_we_i     (io_we_i),
    .host_addr_i   (io_addr_i),
    .host_wdata_i  (io_wdata_i),
    .host_rdata_o  (io_rdata_o),
    .eng_rd_i      (rd_io),
    .eng_wr_i      (wr_io),
    .eng_addr_rd_i (rd_addr),
    .eng_addr_wr_i (wr_addr),
    .eng_wdata_i   (wr_data),
    .eng_rdata_o   (io_eng_rdata)
  );

  sram_bank u_loc_bank (
    .clk (clk), .rst_n (rst_n), .host_en_i (host_en_i),
    .host_req_i    (loc_req_i),
    .host_we_i     (loc_we_i),
    .host_addr_i   (loc_addr_i),
    .host_wdata_i  (loc_wdata_i),
    .host_rdata_o  (loc_rdata_o),
    .eng_rd_i      (rd_loc),
    .eng_wr_i      (wr_loc),
    .eng_addr_rd_i (rd_addr),
    .eng_addr_wr_i (wr_addr),
    .eng_wdata_i   (wr_data),
    .eng_rdata_o   (loc_eng_rdata)
  );

endmodule

//--- logic/op_decoder.sv
module op_decoder
  import octree_store_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  op_code_t    op_i,
  input  pos_encode_t pos_encode_i,
  input  logic        host_en_i,
  input  logic        last_write_i,
  output logic        start_o,
  output op_code_t    op_o,
  output slot_t       slot_o,
  output done_code_t  done_o
);

  op_code_t   prev_op;
  logic       busy;
  logic       launch;
  done_code_t done_code;

  // New command only on an idle-to-active edge of op_i
  assign launch = (op_i != OP_IDLE) && (prev_op == OP_IDLE) && !host_en_i && !busy;

  always_comb begin
    case (op_o)
      OP_SEARCH: done_code = DONE_SEARCH;
      OP_ADD:    done_code = DONE_ADD;
      OP_DEL:    done_code = DONE_DEL;
      default:   done_code = DONE_NONE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prev_op <= OP_IDLE;
      busy    <= 1'b0;
      start_o <= 1'b0;
      op_o    <= OP_IDLE;
      done_o  <= DONE_NONE;
    end else begin
      prev_op <= op_i;
      start_o <= launch;
      if (launch) begin
        busy <= 1'b1;
        op_o <= op_i;
      end else if (last_write_i) begin
        busy <= 1'b0;
      end
      done_o <= last_write_i ? done_code : DONE_NONE;  // One-cycle pulse
    end
  end

  // Slot held for the whole command
  always_ff @(posedge clk) begin
    if (launch) begin
      slot_o <= slot_t'(pos_encode_i[2:0]);
    end
  end

endmodule

//--- logic/sram_bank.sv
module sram_bank (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        host_en_i,
  input  logic                        host_req_i,
  input  logic                        host_we_i,
  input  octree_store_pkg::sram_addr_t host_addr_i,
  input  octree_store_pkg::word_t      host_wdata_i,
  output octree_store_pkg::word_t      host_rdata_o,
  input  logic                        eng_rd_i,
  input  logic                        eng_wr_i,
  input  octree_store_pkg::sram_addr_t eng_addr_rd_i,
  input  octree_store_pkg::sram_addr_t eng_addr_wr_i,
  input  octree_store_pkg::word_t      eng_wdata_i,
  output octree_store_pkg::word_t      eng_rdata_o
);

  localparam int DEPTH = 1 << $bits(octree_store_pkg::sram_addr_t);

  octree_store_pkg::word_t      mem [DEPTH];
  octree_store_pkg::word_t      rdata_q;
  logic                         req;
  logic                         we;
  octree_store_pkg::sram_addr_t addr;
  octree_store_pkg::word_t      wdata;

  ////////////////////
  // Port select
  assign req   = host_en_i ? host_req_i : (eng_rd_i || eng_wr_i);
  assign we    = host_en_i ? host_we_i : eng_wr_i;
  assign addr  = host_en_i ? host_addr_i : (eng_wr_i ? eng_addr_wr_i : eng_addr_rd_i);
  assign wdata = host_en_i ? host_wdata_i : eng_wdata_i;

  always_ff @(posedge clk) begin
    if (req && we) begin
      mem[addr] <= wdata;
    end
  end

  // Read data held until the next read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (req && !we) begin
      rdata_q <= mem[addr];
    end
  end

  assign host_rdata_o = host_en_i ? rdata_q : '0;
  assign eng_rdata_o  = host_en_i ? '0 : rdata_q;

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the octree store testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module octree_store_tb -Mdir "$OBJ" -o vsim -f build.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"$OBJ/vsim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- sim/octree_store_sva.sv
module octree_store_sva
  import octree_store_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input logic       host_en_i,
  input done_code_t done_i,
  input logic       rd_io_i,
  input logic       rd_loc_i,
  input logic       wr_io_i,
  input logic       wr_loc_i
);
  timeunit 1ns;
  timeprecision 100ps;

  done_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    (done_i != DONE_NONE) |=> (done_i == DONE_NONE))
    else $error("done_o held for more than one cycle");

  ////////////////////
  // Engine port use
  no_io_read_write: assert property (@(posedge clk) disable iff (!rst_n)
    !(rd_io_i && wr_io_i))
    else $error("engine read and write on the in/out bank in one cycle");

  no_loc_read_write: assert property (@(posedge clk) disable iff (!rst_n)
    !(rd_loc_i && wr_loc_i))
    else $error("engine read and write on the local bank in one cycle");

  no_engine_in_host_mode: assert property (@(posedge clk) disable iff (!rst_n)
    host_en_i |-> !(rd_io_i || rd_loc_i || wr_io_i || wr_loc_i))
    else $error("engine strobe while the host owns the banks");

endmodule

//--- sim/octree_store_tb.sv
`include "octree_store_config.svh"

module octree_store_tb
  import octree_store_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int FEAT_LEN     = `OS_FEATURE_LENGTH;
  localparam int DONE_LATENCY = `OS_FEATURE_LENGTH + 3;  // Falling edges from op_i to done_o
  localparam int DONE_MAX     = 100;
  localparam int CYCLE_LIMIT  = 4000;  // Well above the ~300 cycles of all tests

  logic        clk, rst_n, host_en_i;
  op_code_t    op_i;
  pos_encode_t pos_encode_i;
  done_code_t  done_o;
  logic        io_req_i, io_we_i, loc_req_i, loc_we_i;
  sram_addr_t  io_addr_i, loc_addr_i;
  word_t       io_wdata_i, io_rdata_o, loc_wdata_i, loc_rdata_o;
  logic [31:0] lcg_state = 32'h420a_7678;
  int          cycle_cnt = 0;

  tb_clock_gen u_clock_gen (.clk(clk), .rst_n(rst_n));
  octree_store_top dut (.*);

  bind octree_store_top octree_store_sva u_sva (
    .clk(clk), .rst_n(rst_n), .host_en_i(host_en_i), .done_i(done_o),
    .rd_io_i(rd_io), .rd_loc_i(rd_loc), .wr_io_i(wr_io), .wr_loc_i(wr_loc)
  );

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) report_failure($sformatf("Error: %s expected %h got %h", name, exp, got));
  endtask

  task automatic check_done(input string name, input done_code_t got, input done_code_t exp);
    if (got !== exp) report_failure($sformatf("Error: %s expected %h got %h", name, exp, got));
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic word_t rand_word();
    return {lcg_next(), lcg_next()};
  endfunction

  function automatic sram_addr_t slot_addr(input slot_t slot, input int item);
    return sram_addr_t'(`OS_FEATURE_BASE + int'(slot) * FEAT_LEN + item);
  endfunction

  ////////////////////
  // Host port access
  task automatic host_write(input bit to_loc, input sram_addr_t addr, input word_t data);
    @(negedge clk);
    if (to_loc) {loc_req_i, loc_we_i, loc_addr_i, loc_wdata_i} = {2'b11, addr, data};
    else {io_req_i, io_we_i, io_addr_i, io_wdata_i} = {2'b11, addr, data};
    @(negedge clk);
    {loc_req_i, loc_we_i, io_req_i, io_we_i} = 4'b0;
  endtask

  task automatic check_bank(input bit to_loc, input sram_addr_t addr, input word_t exp);
    @(negedge clk);
    if (to_loc) {loc_req_i, loc_we_i, loc_addr_i} = {2'b10, addr};
    else {io_req_i, io_we_i, io_addr_i} = {2'b10, addr};
    @(negedge clk);  // Read data one cycle later
    {loc_req_i, io_req_i} = 2'b0;
    if (to_loc) check_word($sformatf("loc_rdata_o[%0d]", addr), loc_rdata_o, exp);
    else check_word($sformatf("io_rdata_o[%0d]", addr), io_rdata_o, exp);
  endtask

  // Issue one command, wait for done_o, optionally keep op_i held
  task automatic run_command(input op_code_t op, input done_code_t exp_done, input slot_t slot,
                             input int hold_cycles, output int latency);
    logic [31:0] r;
    r = lcg_next();
    @(negedge clk);
    host_en_i = 1'b0;
    @(negedge clk);
    op_i = op;
    pos_encode_i = pos_encode_t'({r[10:0], slot});  // Upper levels are don't care
    latency = 0;
    do begin
      @(negedge clk);
      latency++;
    end while (done_o == DONE_NONE && latency < DONE_MAX);
    if (done_o == DONE_NONE) report_failure($sformatf("No done_o for command %s", op.name()));
    check_done("done_o", done_o, exp_done);
    repeat (hold_cycles) begin
      @(negedge clk);
      if (done_o != DONE_NONE) report_failure("A second done_o came for a held command");
    end
    op_i = OP_IDLE;
    @(negedge clk);
    host_en_i = 1'b1;
  endtask

  ////////////////////
  // Directed tests
  task automatic test_host_access();
    word_t io_w [4];
    word_t loc_w [4];
    for (int i = 0; i < 4; i++) begin
      io_w[i]  = rand_word();
      loc_w[i] = rand_word();
      host_write(1'b0, sram_addr_t'(i * 97 + 5), io_w[i]);
      host_write(1'b1, sram_addr_t'(i * 131 + 600), loc_w[i]);
    end
    for (int i = 0; i < 4; i++) begin
      check_bank(1'b0, sram_addr_t'(i * 97 + 5), io_w[i]);
      check_bank(1'b1, sram_addr_t'(i * 131 + 600), loc_w[i]);
    end
    @(negedge clk);
    host_en_i = 1'b0;  // Host loses the banks
    {io_req_i, loc_req_i} = 2'b11;
    @(negedge clk);
    {io_req_i, loc_req_i} = 2'b00;
    check_word("io_rdata_o", io_rdata_o, word_t'(0));
    check_word("loc_rdata_o", loc_rdata_o, word_t'(0));
    host_en_i = 1'b1;
  endtask

  task automatic test_add();
    word_t in_w [FEAT_LEN];
    int    latency;
    for (int i = 0; i < FEAT_LEN; i++) begin
      in_w[i] = rand_word();
      host_write(1'b0, sram_addr_t'(`OS_INPUT_BASE + i), in_w[i]);
    end
    run_command(OP_ADD, DONE_ADD, 3'd5, 0, latency);
    for (int i = 0; i < FEAT_LEN; i++) check_bank(1'b1, slot_addr(3'd5, i), in_w[i]);
  endtask

  task automatic test_search();
    word_t slot_w [FEAT_LEN];
    int    latency;
    for (int i = 0; i < FEAT_LEN; i++) begin
      slot_w[i] = rand_word();
      host_write(1'b1, slot_addr(3'd2, i), slot_w[i]);
    end
    run_command(OP_SEARCH, DONE_SEARCH, 3'd2, 0, latency);
    for (int i = 0; i < FEAT_LEN; i++) begin
      check_bank(1'b0, sram_addr_t'(`OS_OUTPUT_BASE + i), slot_w[i]);
    end
  endtask

  task automatic test_delete();
    word_t keep_w [FEAT_LEN];
    int    latency;
    for (int i = 0; i < FEAT_LEN; i++) begin
      keep_w[i] = rand_word();
      host_write(1'b1, slot_addr(3'd3, i), rand_word());
      host_write(1'b1, slot_addr(3'd4, i), keep_w[i]);
    end
    run_command(OP_DEL, DONE_DEL, 3'd3, 0, latency);
    for (int i = 0; i < FEAT_LEN; i++) begin
      check_bank(1'b1, slot_addr(3'd3, i), word_t'(0));
      check_bank(1'b1, slot_addr(3'd4, i), keep_w[i]);
    end
  endtask

  task automatic test_done_timing();
    int latency;
    run_command(OP_ADD, DONE_ADD, 3'd1, 40, latency);
    if (latency != DONE_LATENCY) begin
      report_failure($sformatf("Error: done latency expected %h got %h", DONE_LATENCY, latency));
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) report_failure("Timeout: the tests did not finish in time");
  end

  initial begin
    op_i = OP_IDLE;
    pos_encode_i = '0;
    host_en_i = 1'b1;
    {io_req_i, io_we_i, io_addr_i, io_wdata_i} = '0;
    {loc_req_i, loc_we_i, loc_addr_i, loc_wdata_i} = '0;
    @(posedge rst_n);
    test_host_access();
    test_add();
    test_search();
    test_delete();
    test_done_timing();
    @(negedge clk);
    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- sim/tb_clock_gen.sv
module tb_clock_gen (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  // Five rising edges in reset, release away from the edge
  initial begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule
